/* hw/rv32i_consts.svh */
`ifndef RV32I_CONSTS_SVH
`define RV32I_CONSTS_SVH

// Core data and address width
`define RV_XLEN 32

// Depth of each RAM slave in 32-bit words
`define RAM_DEPTH_WORDS 1024

// Byte base addresses of the two RAM regions
`define RAM0_BASE 32'h0000_0000
`define RAM1_BASE 32'h1000_0000

// Size of one decoded region in bytes, matches one RAM
`define REGION_BYTES 4096

`endif

/* hw/rv32i_lsu_pkg.sv */
`include "rv32i_consts.svh"

package rv32i_lsu_pkg;

  // One core data or address word
  typedef logic [`RV_XLEN-1:0] xword_t;

  // Access size as encoded by the load/store instructions
  // Code 3 is not a legal funct3 width, the memory stage treats it as a byte
  typedef enum logic [1:0] {
    MEM_BYTE     = 2'd0,
    MEM_HALF     = 2'd1,
    MEM_WORD     = 2'd2,
    MEM_BYTE_ALT = 2'd3
  } mem_size_e;

endpackage

/* hw/wb_pkg.sv */
`include "rv32i_consts.svh"

package wb_pkg;

  // Word address, byte address bits 31 down to 2
  typedef logic [`RV_XLEN-3:0] wb_adr_t;

  // Bus data word
  typedef logic [`RV_XLEN-1:0] wb_dat_t;

  // One select bit per byte lane
  typedef logic [`RV_XLEN/8-1:0] wb_sel_t;

endpackage

/* hw/wb_if.sv */
interface wb_if;
  import wb_pkg::*;

  // Request side, driven by the master
  wb_adr_t adr;
  wb_dat_t dat_w;
  wb_sel_t sel;
  logic    cyc;
  logic    stb;
  logic    we;

  // Response side, driven by the slave
  wb_dat_t dat_r;
  logic    ack;
  logic    err;

  modport master (
    output adr, dat_w, sel, cyc, stb, we,
    input  dat_r, ack, err
  );

  modport slave (
    input  adr, dat_w, sel, cyc, stb, we,
    output dat_r, ack, err
  );

endinterface

/* hw/rv32i_memory_pipe.sv */
`include "rv32i_consts.svh"

module rv32i_memory_pipe (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     clear_i,
  input  logic                     data_ready_i,
  input  rv32i_lsu_pkg::xword_t    data_i,
  input  rv32i_lsu_pkg::xword_t    addr_i,
  input  rv32i_lsu_pkg::mem_size_e word_size_i,
  input  logic                     write_i,
  output rv32i_lsu_pkg::xword_t    data_o,
  output logic                     busy_o,
  output logic                     err_o,
  wb_if.master                     bus
);
  import rv32i_lsu_pkg::*;
  import wb_pkg::*;

  wb_sel_t sel_next;
  wb_sel_t sel_q;
  wb_adr_t adr_q;
  wb_dat_t dat_w_q;
  logic    stb_q;
  logic    we_q;
  logic    take_req;

  // New request only when no cycle is open
  assign take_req = data_ready_i && !stb_q;

  // Lane selects from size and low address bits
  // Data is not shifted, lanes just mark which bytes are valid
  always_comb begin
    case (word_size_i)
      MEM_HALF: sel_next = addr_i[1] ? 4'b1100 : 4'b0011;
      MEM_WORD: sel_next = 4'b1111;
      // Byte, and the unused code 3
      default:  sel_next = wb_sel_t'(4'b0001 << addr_i[1:0]);
    endcase
  end

  // Control state of the single open cycle
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      sel_q  <= '0;
      busy_o <= 1'b0;
      err_o  <= 1'b0;
    end else if (clear_i) begin
      // Flush, also abandons an open cycle
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      sel_q  <= '0;
      busy_o <= 1'b0;
      err_o  <= 1'b0;
    end else if (take_req) begin
      stb_q  <= 1'b1;
      we_q   <= write_i;
      sel_q  <= sel_next;
      busy_o <= 1'b1;
    end else if (bus.ack) begin
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      busy_o <= 1'b0;
    end else if (bus.err) begin
      // Unmapped address, error stays until reset or flush
      stb_q  <= 1'b0;
      we_q   <= 1'b0;
      busy_o <= 1'b0;
      err_o  <= 1'b1;
    end
  end

  // Payload registers
  always_ff @(posedge clk_i) begin
    if (take_req) begin
      adr_q   <= addr_i[`RV_XLEN-1:2];
      dat_w_q <= data_i;
    end
    // Full word comes back as is
    if (stb_q && bus.ack) begin
      data_o <= bus.dat_r;
    end
  end

  // Single master, so cyc follows stb
  assign bus.cyc   = stb_q;
  assign bus.stb   = stb_q;
  assign bus.we    = we_q;
  assign bus.sel   = sel_q;
  assign bus.adr   = adr_q;
  assign bus.dat_w = dat_w_q;

endmodule

/* hw/wb_addr_decoder.sv */
`include "rv32i_consts.svh"

module wb_addr_decoder (
  wb_if.slave  m,
  wb_if.master s0,
  wb_if.master s1
);
  import wb_pkg::*;

  // Word address width and word offset bits inside one region
  localparam int ADR_W    = $bits(wb_adr_t);
  localparam int OFF_BITS = $clog2(`REGION_BYTES) - 2;

  // Region bases as word addresses
  localparam wb_adr_t RAM0_WADR = wb_adr_t'(`RAM0_BASE >> 2);
  localparam wb_adr_t RAM1_WADR = wb_adr_t'(`RAM1_BASE >> 2);

  logic hit0;
  logic hit1;

  // Region match on the bits above the offset
  assign hit0 = (m.adr[ADR_W-1:OFF_BITS] == RAM0_WADR[ADR_W-1:OFF_BITS]);
  assign hit1 = (m.adr[ADR_W-1:OFF_BITS] == RAM1_WADR[ADR_W-1:OFF_BITS]);

  // Request fields go to both slaves
  assign s0.adr   = m.adr;
  assign s0.dat_w = m.dat_w;
  assign s0.sel   = m.sel;
  assign s0.we    = m.we;
  assign s1.adr   = m.adr;
  assign s1.dat_w = m.dat_w;
  assign s1.sel   = m.sel;
  assign s1.we    = m.we;

  // Only the matching slave sees a cycle
  assign s0.cyc = m.cyc && hit0;
  assign s0.stb = m.stb && hit0;
  assign s1.cyc = m.cyc && hit1;
  assign s1.stb = m.stb && hit1;

  // Response mux back to the master
  always_comb begin
    if (hit0) begin
      m.dat_r = s0.dat_r;
      m.ack   = s0.ack;
    end else if (hit1) begin
      m.dat_r = s1.dat_r;
      m.ack   = s1.ack;
    end else begin
      m.dat_r = '0;
      m.ack   = 1'b0;
    end
  end

  // Unmapped access errors right away and for as long as stb is up
  assign m.err = m.stb && !hit0 && !hit1;

endmodule

/* hw/wb_sram.sv */
`include "rv32i_consts.svh"

module wb_sram #(
  parameter int DEPTH_WORDS = `RAM_DEPTH_WORDS
) (
  input  logic clk_i,
  input  logic rst_n_i,
  wb_if.slave  bus
);
  import wb_pkg::*;

  localparam int IDX_W = $clog2(DEPTH_WORDS);
  localparam int SEL_W = $bits(wb_sel_t);

  wb_dat_t           mem [DEPTH_WORDS];
  wb_dat_t           rdata_q;
  logic              ack_q;
  logic              req;
  logic [IDX_W-1:0]  idx;

  // Word index inside the region as the decoder already matched the upper bits
  assign idx = bus.adr[IDX_W-1:0];

  // One ack per strobe and none while the last one is still up
  assign req = bus.cyc && bus.stb && !ack_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req;
    end
  end

  // Write lanes and read word land on the same edge as ack
  always_ff @(posedge clk_i) begin
    if (req) begin
      if (bus.we) begin
        for (int b = 0; b < SEL_W; b++) begin
          if (bus.sel[b]) begin
            mem[idx][8*b +: 8] <= bus.dat_w[8*b +: 8];
          end
        end
      end
      // Read returns the old word on a write
      rdata_q <= mem[idx];
    end
  end

  assign bus.dat_r = rdata_q;
  assign bus.ack   = ack_q;

endmodule

/* hw/rv32i_mem_subsys.sv */
`include "rv32i_consts.svh"

module rv32i_mem_subsys (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     clear_i,
  input  logic                     data_ready_i,
  input  rv32i_lsu_pkg::xword_t    data_i,
  input  rv32i_lsu_pkg::xword_t    addr_i,
  input  rv32i_lsu_pkg::mem_size_e word_size_i,
  input  logic                     write_i,
  output rv32i_lsu_pkg::xword_t    data_o,
  output logic                     busy_o,
  output logic                     err_o
);

  // Memory stage to decoder
  wb_if core_bus ();
  // Decoder to each RAM
  wb_if ram0_bus ();
  wb_if ram1_bus ();

  rv32i_memory_pipe u_memory_pipe (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .clear_i      (clear_i),
    .data_ready_i (data_ready_i),
    .data_i       (data_i),
    .addr_i       (addr_i),
    .word_size_i  (word_size_i),
    .write_i      (write_i),
    .data_o       (data_o),
    .busy_o       (busy_o),
    .err_o        (err_o),
    .bus          (core_bus.master)
  );

  wb_addr_decoder u_addr_decoder (
    .m  (core_bus.slave),
    .s0 (ram0_bus.master),
    .s1 (ram1_bus.master)
  );

  wb_sram #(
    .DEPTH_WORDS (`RAM_DEPTH_WORDS)
  ) u_ram0 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (ram0_bus.slave)
  );

  wb_sram #(
    .DEPTH_WORDS (`RAM_DEPTH_WORDS)
  ) u_ram1 (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .bus     (ram1_bus.slave)
  );

endmodule

/* test/rv32i_mem_subsys_tb.sv */
`include "rv32i_consts.svh"

module rv32i_mem_subsys_tb;
  import rv32i_lsu_pkg::*;
  import wb_pkg::*;

  localparam int IDX_W = $clog2(`RAM_DEPTH_WORDS);

  // Plain access, second request while busy, flush mid cycle, flush while idle
  typedef enum logic [2:0] {OP_WR, OP_RD, OP_OVERLAP, OP_ABORT, OP_CLEAR} op_e;

  // One table row where rnd takes write data from $urandom instead of wdata
  typedef struct {
    op_e       op;
    xword_t    addr;
    mem_size_e size;
    logic      rnd;
    xword_t    wdata;
    logic      exp_err;
  } entry_t;

  logic      clk;
  logic      rst_n;
  logic      clear;
  logic      data_ready;
  xword_t    data_in;
  xword_t    addr;
  mem_size_e word_size;
  logic      write;
  xword_t    data_out;
  logic      busy;
  logic      err;

  entry_t stim_q [$];
  // Reference words with index 0 for RAM0 and index 1 for RAM1
  xword_t ram_model [2][`RAM_DEPTH_WORDS];
  int     cycle_count = 0;
  int     cycle_limit;
  logic   err_expect;

  rv32i_mem_subsys u_rv32i_mem_subsys (
    .clk_i        (clk),
    .rst_n_i      (rst_n),
    .clear_i      (clear),
    .data_ready_i (data_ready),
    .data_i       (data_in),
    .addr_i       (addr),
    .word_size_i  (word_size),
    .write_i      (write),
    .data_o       (data_out),
    .busy_o       (busy),
    .err_o        (err)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Run limit from the table length
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_limit > 0 && cycle_count > cycle_limit) begin
      $display("Timeout after %0d cycles, the table did not complete", cycle_count);
      $display("Finished with errors");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic stop_run();
    $display("Finished with errors");
    $fatal(1, "first mismatch ends the run");
  endtask

  task automatic check_word(input string name, input xword_t got, input xword_t exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic check_latency(input string name, input int got, input int exp);
    if (got != exp) begin
      $display("FAILED at %0t: %s got %0d expected %0d", $time, name, got, exp);
      stop_run();
    end
  endtask

  // Byte lanes touched by an access
  function automatic wb_sel_t lane_mask(input mem_size_e sz, input xword_t a);
    case (sz)
      MEM_WORD: return 4'b1111;
      MEM_HALF: return a[1] ? 4'b1100 : 4'b0011;
      default:  return 4'b0001 << a[1:0];
    endcase
  endfunction

  // 1 for the RAM1 region, 0 for RAM0
  function automatic int region_of(input xword_t a);
    return ((a & ~xword_t'(`REGION_BYTES - 1)) == `RAM1_BASE) ? 1 : 0;
  endfunction

  // Data is lane aligned so only the selected bytes change
  task automatic model_write(input xword_t a, input mem_size_e sz, input xword_t d);
    wb_sel_t m;
    m = lane_mask(sz, a);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) begin
        ram_model[region_of(a)][a[IDX_W+1:2]][8*b +: 8] = d[8*b +: 8];
      end
    end
  endtask

  task automatic add_entry(input op_e op, input xword_t a, input mem_size_e sz,
                           input logic rnd, input xword_t d, input logic exp_err);
    entry_t e;
    e = '{op, a, sz, rnd, d, exp_err};
    stim_q.push_back(e);
  endtask

  // Sample busy each falling edge until the cycle is over
  task automatic wait_done(inout int lat);
    @(negedge clk);
    while (busy) begin
      lat++;
      @(negedge clk);
    end
  endtask

  task automatic run_entry(input entry_t e);
    xword_t wdata;
    int     lat;
    int     exp_lat;
    lat = 0;
    wdata = e.rnd ? xword_t'($urandom) : e.wdata;
    while (busy) @(negedge clk);
    @(posedge clk);
    if (e.op == OP_CLEAR) begin
      clear <= 1'b1;
    end else begin
      data_ready <= 1'b1;
      addr       <= e.addr;
      word_size  <= e.size;
      write      <= (e.op != OP_RD && e.op != OP_ABORT);
      data_in    <= wdata;
    end
    // Request taken on this edge
    @(posedge clk);
    case (e.op)
      // Second write while busy that the DUT must drop
      OP_OVERLAP: data_in <= ~wdata;
      OP_ABORT: begin
        data_ready <= 1'b0;
        clear      <= 1'b1;
      end
      default: begin
        data_ready <= 1'b0;
        clear      <= 1'b0;
      end
    endcase
    @(negedge clk);
    if (busy) lat++;
    @(posedge clk);
    // Overlapping request stays up through the edge where ack arrives
    if (e.op == OP_OVERLAP) begin
      @(negedge clk);
      if (busy) lat++;
      @(posedge clk);
    end
    data_ready <= 1'b0;
    clear      <= 1'b0;
    wait_done(lat);
    case (e.op)
      OP_CLEAR: exp_lat = 0;
      OP_ABORT: exp_lat = 1;
      default:  exp_lat = e.exp_err ? 1 : 2;
    endcase
    if (e.op == OP_CLEAR || e.op == OP_ABORT) begin
      err_expect = 1'b0;
    end else if (e.exp_err) begin
      err_expect = 1'b1;
    end else if (e.op != OP_RD) begin
      model_write(e.addr, e.size, wdata);
    end
    check_latency("busy_o cycles", lat, exp_lat);
    check_flag("busy_o", busy, 1'b0);
    check_flag("err_o", err, err_expect);
    // Loads return the whole word for any size
    if (e.op == OP_RD && !e.exp_err) begin
      check_word("data_o", data_out, ram_model[region_of(e.addr)][e.addr[IDX_W+1:2]]);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    clear       = 1'b0;
    data_ready  = 1'b0;
    data_in     = '0;
    addr        = '0;
    word_size   = MEM_WORD;
    write       = 1'b0;
    err_expect  = 1'b0;
    void'($urandom(75));
    // Same offset in both regions to show there is no aliasing
    add_entry(OP_WR, 32'h0000_0010, MEM_WORD, 1'b0, 32'hcafe_0001, 1'b0);
    add_entry(OP_WR, 32'h1000_0010, MEM_WORD, 1'b0, 32'h5a5a_1234, 1'b0);
    add_entry(OP_RD, 32'h0000_0010, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h1000_0010, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0ffc, MEM_WORD, 1'b1, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0ffc, MEM_WORD, 1'b0, 32'h0, 1'b0);
    // Byte lanes one at a time with size code 3 on the top lane
    add_entry(OP_WR, 32'h0000_0020, MEM_WORD, 1'b0, 32'ha5a5_a5a5, 1'b0);
    add_entry(OP_WR, 32'h0000_0020, MEM_BYTE, 1'b1, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0021, MEM_BYTE, 1'b1, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0022, MEM_BYTE, 1'b1, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_0023, MEM_BYTE_ALT, 1'b1, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0020, MEM_WORD, 1'b0, 32'h0, 1'b0);
    // Half words in region 1 where a byte read still gives the full word
    add_entry(OP_WR, 32'h1000_0040, MEM_WORD, 1'b1, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h1000_0042, MEM_HALF, 1'b1, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h1000_0041, MEM_BYTE, 1'b0, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h1000_0040, MEM_HALF, 1'b1, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h1000_0040, MEM_WORD, 1'b0, 32'h0, 1'b0);
    // Unmapped accesses with a sticky error until the flush
    add_entry(OP_RD, 32'h2000_0000, MEM_WORD, 1'b0, 32'h0, 1'b1);
    add_entry(OP_RD, 32'h0000_0010, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_WR, 32'h0000_1000, MEM_WORD, 1'b1, 32'h0, 1'b1);
    add_entry(OP_CLEAR, 32'h0, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h1000_0010, MEM_WORD, 1'b0, 32'h0, 1'b0);
    // Ignored second request and a flush in the middle of a read
    add_entry(OP_OVERLAP, 32'h0000_0030, MEM_WORD, 1'b1, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h0000_0030, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_ABORT, 32'h1000_0040, MEM_WORD, 1'b0, 32'h0, 1'b0);
    add_entry(OP_RD, 32'h1000_0040, MEM_WORD, 1'b0, 32'h0, 1'b0);
    cycle_limit = 20 * stim_q.size() + 50;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("busy_o", busy, 1'b0);
    check_flag("err_o", err, 1'b0);
    foreach (stim_q[i]) begin
      run_entry(stim_q[i]);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

/* flist.f */
+incdir+hw
hw/rv32i_lsu_pkg.sv
hw/wb_pkg.sv
hw/wb_if.sv
hw/rv32i_memory_pipe.sv
hw/wb_addr_decoder.sv
hw/wb_sram.sv
hw/rv32i_mem_subsys.sv
test/rv32i_mem_subsys_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it and look for the pass line
set -u
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f flist.f --top-module rv32i_mem_subsys_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/Vrv32i_mem_subsys_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "Pass line not found in simulation output"
exit 1
